/* files.f */
+incdir+design
design/fpDivSqrtPkg.sv
design/flushRangeDetector.sv
design/fp32DivSqrter.sv
design/fpDivSqrtUnit.sv
design/divSqrtWritebackArbiter.sv
design/fpDivSqrtSubsystem.sv
tests/fpDivSqrtSubsystemTb.sv

/* run.sh */
#!/bin/sh
# Build and run the testbench with Verilator, then check the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
(verilator --binary -Wno-fatal -f files.f --top-module fpDivSqrtSubsystemTb -o simv &&
    ./obj_dir/simv) > sim.log 2>&1 || echo "Testbench failed" >> sim.log
cat sim.log
! grep -q "Testbench failed" sim.log && echo "Simulation passed" || { echo "Simulation failed"; exit 1; }

/* tests/fpDivSqrtSubsystemTb.sv */
//////////////////////////////
// Testbench for the FP divide/sqrt block
//////////////////////////////

`include "fpDivSqrt_consts.svh"

module fpDivSqrtSubsystemTb import fpDivSqrtPkg::*; ();

    localparam int Width = `FP_DIVSQRT_WIDTH;
    localparam int Iters = `DIVSQRT_ITERATIONS;
    localparam int NumOps = 22;
    localparam int LaneBits = (Width > 1) ? $clog2(Width) : 1;
    localparam int NumPtrs = 1 << `ACTIVE_LIST_PTR_BITS;

    logic                clk;
    logic                rstN;
    logic [Width-1:0]    acquire;
    ActiveListPtr        acquirePtr [Width];
    logic [Width-1:0]    req;
    FpOp                 op [Width];
    logic [31:0]         dataA [Width];
    logic [31:0]         dataB [Width];
    logic                toRecovery;
    ActiveListPtr        flushHeadPtr;
    ActiveListPtr        flushTailPtr;
    logic                flushAll;
    logic                wbStall;
    logic [Width-1:0]    free;
    logic [Width-1:0]    busy;
    logic [Width-1:0]    reserved;
    logic                wbValid;
    logic [LaneBits-1:0] wbLane;
    ActiveListPtr        wbPtr;
    logic [31:0]         wbData;

    // Reference results, indexed by active-list pointer
    logic [31:0] expected [NumPtrs];
    int          expLane [NumPtrs];
    bit          pending [NumPtrs];
    int          pendingCount;
    int          wbCount;
    int          lastWbCycle;
    int          cycle;
    int          wbLanes [$];
    integer      seed;

    fpDivSqrtSubsystem i_fpDivSqrtSubsystem (
        .clk(clk), .rstN(rstN), .acquire(acquire), .acquirePtr(acquirePtr),
        .req(req), .op(op), .dataA(dataA), .dataB(dataB),
        .toRecovery(toRecovery), .flushHeadPtr(flushHeadPtr),
        .flushTailPtr(flushTailPtr), .flushAll(flushAll), .wbStall(wbStall),
        .free(free), .busy(busy), .reserved(reserved), .wbValid(wbValid),
        .wbLane(wbLane), .wbPtr(wbPtr), .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) cycle <= cycle + 1;

    task reportFail(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        $display("Testbench failed");
        $fatal(1);
    endtask

    // Truncating divide and square root on the integer mantissas
    function automatic logic [31:0] modelResult(FpOp o, logic [31:0] a, logic [31:0] b);
        longint ma;
        longint mb;
        longint q;
        longint rad;
        longint root;
        longint trial;
        int     e;
        if (o == opDiv) begin
            if (b[30:23] == 0) return {a[31] ^ b[31], 8'hff, 23'd0};
            if (a[30:23] == 0) return {a[31] ^ b[31], 31'd0};
            ma = {40'd0, 1'b1, a[22:0]};
            mb = {40'd0, 1'b1, b[22:0]};
            q = (ma << 25) / mb;
            e = int'(a[30:23]) - int'(b[30:23]) + 127;
            if (q[25]) return {a[31] ^ b[31], 8'(e), q[24:2]};
            return {a[31] ^ b[31], 8'(e - 1), q[23:1]};
        end
        if (a[30:23] == 0) return {a[31], 31'd0};
        if (a[31]) return 32'h7fc00000;
        ma = {40'd0, 1'b1, a[22:0]};
        e = int'(a[30:23]) - 127;
        rad = (e & 1) ? (ma << 28) : (ma << 27);
        root = 0;
        for (int k = 25; k >= 0; k--) begin
            trial = root | (64'd1 << k);
            if (trial * trial <= rad) begin
                root = trial;
            end
        end
        return {1'b0, 8'((e - (e & 1)) / 2 + 127), root[24:2]};
    endfunction

    function automatic logic [31:0] randOperand(bit positive);
        logic [31:0] r;
        logic [31:0] ex;
        r = $random(seed);
        ex = $random(seed);
        return {positive ? 1'b0 : r[31], 8'(100 + (ex % 51 + 51) % 51), r[22:0]};
    endfunction

    // Each writeback must match a pending pointer, its lane and its model result
    always @(negedge clk) begin
        if (rstN && wbValid) begin
            assert (pending[wbPtr])
                else reportFail($sformatf("writeback of unexpected pointer %0d", wbPtr));
            assert (int'(wbLane) == expLane[wbPtr])
                else reportFail($sformatf("ptr %0d on lane %0d, expected lane %0d",
                                          wbPtr, wbLane, expLane[wbPtr]));
            assert (wbData == expected[wbPtr])
                else reportFail($sformatf("ptr %0d data %h, expected %h",
                                          wbPtr, wbData, expected[wbPtr]));
            pending[wbPtr] = 1'b0;
            pendingCount--;
            wbCount++;
            lastWbCycle = cycle;
            wbLanes.push_back(int'(wbLane));
        end
    end

    assert property (@(posedge clk) disable iff (!rstN) wbStall |=> !wbValid)
        else reportFail("wbValid high while writeback was stalled");

    task checkIdle();
        @(negedge clk);
        assert (free == '1 && busy == '0 && reserved == '0 && !wbValid)
            else reportFail("lanes not idle after reset");
    endtask

    task issueOp(input int lane, input ActiveListPtr ptr, input FpOp o,
                 input logic [31:0] a, input logic [31:0] b, output int reqEdge);
        @(posedge clk);
        acquire[lane] <= 1'b1;
        acquirePtr[lane] <= ptr;
        @(posedge clk);
        acquire[lane] <= 1'b0;
        req[lane] <= 1'b1;
        op[lane] <= o;
        dataA[lane] <= a;
        dataB[lane] <= b;
        expected[ptr] = modelResult(o, a, b);
        expLane[ptr] = lane;
        pending[ptr] = 1'b1;
        pendingCount++;
        @(negedge clk);
        assert (reserved[lane] && !free[lane])
            else reportFail($sformatf("lane %0d not reserved after acquire", lane));
        reqEdge = cycle + 1;
        @(posedge clk);
        req[lane] <= 1'b0;
        @(negedge clk);
        assert (busy[lane])
            else reportFail($sformatf("lane %0d not busy after req", lane));
    endtask

    task waitWritebacks(input int target);
        int waited;
        waited = 0;
        while (wbCount < target) begin
            @(posedge clk);
            waited++;
            if (waited > 2 * Iters + 20) reportFail("no writeback arrived in time");
        end
    endtask

    // Single lane, no stall, checks value and exact latency
    task runSingle(input int lane, input ActiveListPtr ptr, input FpOp o,
                   input logic [31:0] a, input logic [31:0] b);
        int reqEdge;
        int target;
        target = wbCount + 1;
        issueOp(lane, ptr, o, a, b, reqEdge);
        waitWritebacks(target);
        assert (lastWbCycle - reqEdge == Iters + 3)
            else reportFail($sformatf("latency %0d cycles", lastWbCycle - reqEdge));
    endtask

    task waitAllWaiting();
        int waited;
        waited = 0;
        @(negedge clk);
        while ((busy | reserved | free) != '0) begin
            @(negedge clk);
            waited++;
            if (waited > Iters + 20) reportFail("lanes never reached the waiting phase");
        end
    endtask

    task flushPulse(input ActiveListPtr head, input ActiveListPtr tail, input logic all,
                    input logic [Width-1:0] hitMask, input ActiveListPtr hitPtrs [Width]);
        @(posedge clk);
        toRecovery <= 1'b1;
        flushAll <= all;
        flushHeadPtr <= head;
        flushTailPtr <= tail;
        for (int i = 0; i < Width; i++) begin
            if (hitMask[i]) begin
                pending[hitPtrs[i]] = 1'b0;
                pendingCount--;
            end
        end
        @(negedge clk);
        assert ((free & hitMask) == hitMask) else reportFail("flushed lane not reported free");
        @(posedge clk);
        toRecovery <= 1'b0;
        flushAll <= 1'b0;
        @(negedge clk);
        assert ((busy & hitMask) == '0) else reportFail("flushed lane still busy");
    endtask

    initial begin
        int          reqEdge;
        int          target;
        int          ptr;
        int          firstLane;
        ActiveListPtr hitPtrs [Width];
        seed = 32'head5;
        rstN = 1'b0;
        acquire = '0;
        req = '0;
        toRecovery = 1'b0;
        flushAll = 1'b0;
        flushHeadPtr = '0;
        flushTailPtr = '0;
        wbStall = 1'b0;
        for (int i = 0; i < Width; i++) begin
            acquirePtr[i] = '0;
            op[i] = opDiv;
            dataA[i] = '0;
            dataB[i] = '0;
        end
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();

        ptr = 0;
        for (int n = 0; n < 8; n++) begin
            runSingle(n % Width, 6'(ptr), (n % 2) ? opSqrt : opDiv,
                      randOperand(n % 2 == 1), randOperand(1'b0));
            ptr++;
        end
        runSingle(0, 6'(ptr), opDiv, randOperand(1'b0), 32'h80000000);
        runSingle(1, 6'(ptr + 1), opDiv, 32'h80000000, randOperand(1'b0));
        runSingle(0, 6'(ptr + 2), opSqrt, randOperand(1'b1) | 32'h80000000, 32'd0);
        runSingle(1, 6'(ptr + 3), opSqrt, 32'h00000000, 32'd0);

        // Both lanes finish behind a stall, then drain in turns
        for (int r = 0; r < 2; r++) begin
            // A lane 0 writeback moves the priority on to lane 1
            if (r == 1) begin
                runSingle(0, 6'd40, opDiv, randOperand(1'b0), randOperand(1'b0));
            end
            firstLane = (wbLanes[$] + 1) % Width;
            @(posedge clk);
            wbStall <= 1'b1;
            target = wbCount + 2;
            issueOp(0, 6'(20 + 2 * r), opDiv, randOperand(1'b0), randOperand(1'b0), reqEdge);
            issueOp(1, 6'(21 + 2 * r), opSqrt, randOperand(1'b1), 32'd0, reqEdge);
            waitAllWaiting();
            assert (wbCount == target - 2) else reportFail("writeback during stall");
            @(posedge clk);
            wbStall <= 1'b0;
            waitWritebacks(target);
            assert (wbLanes[$-1] == firstLane && wbLanes[$] != firstLane)
                else reportFail("lanes did not take turns in round-robin order");
        end

        // Wrapped range 60..2 catches lane 0 only
        target = wbCount + 1;
        issueOp(0, 6'd62, opDiv, randOperand(1'b0), randOperand(1'b0), reqEdge);
        issueOp(1, 6'd5, opDiv, randOperand(1'b0), randOperand(1'b0), reqEdge);
        hitPtrs[0] = 6'd62;
        hitPtrs[1] = 6'd5;
        flushPulse(6'd60, 6'd3, 1'b0, 2'b01, hitPtrs);
        waitWritebacks(target);

        target = wbCount;
        issueOp(0, 6'd30, opSqrt, randOperand(1'b1), 32'd0, reqEdge);
        issueOp(1, 6'd31, opDiv, randOperand(1'b0), randOperand(1'b0), reqEdge);
        hitPtrs[0] = 6'd30;
        hitPtrs[1] = 6'd31;
        flushPulse(6'd0, 6'd0, 1'b1, 2'b11, hitPtrs);

        // Reset in the middle of an operation drops it
        issueOp(0, 6'd41, opDiv, randOperand(1'b0), randOperand(1'b0), reqEdge);
        pending[41] = 1'b0;
        pendingCount--;
        @(posedge clk);
        rstN <= 1'b0;
        repeat (4) @(posedge clk);
        rstN <= 1'b1;
        checkIdle();

        repeat (Iters + 10) @(posedge clk);
        assert (wbCount == target) else reportFail("cancelled operation wrote back");

        if (pendingCount != 0) begin
            reportFail($sformatf("%0d results never written back", pendingCount));
        end
        else begin
            $display("Testbench passed");
            $finish;
        end
    end

    initial begin
        cycle = 0;
        wbCount = 0;
        pendingCount = 0;
        lastWbCycle = 0;
        for (int i = 0; i < NumPtrs; i++) begin
            pending[i] = 1'b0;
            expLane[i] = -1;
        end
    end

    initial begin
        #((NumOps * (Iters + 10) + 200) * 100);
        $display("Watchdog expired before all tests completed");
        $display("Testbench failed");
        $fatal(1);
    end

endmodule

/* design/fpDivSqrtSubsystem.sv */
//////////////////////////////
// FP divide/sqrt block, lanes plus writeback
//////////////////////////////

`include "fpDivSqrt_consts.svh"

module fpDivSqrtSubsystem import fpDivSqrtPkg::*; #(
    parameter int LaneBits = (`FP_DIVSQRT_WIDTH > 1) ? $clog2(`FP_DIVSQRT_WIDTH) : 1
) (
    input  logic                         clk,
    input  logic                         rstN,

    // Issue side
    input  logic [`FP_DIVSQRT_WIDTH-1:0] acquire,
    input  ActiveListPtr                 acquirePtr [`FP_DIVSQRT_WIDTH],
    input  logic [`FP_DIVSQRT_WIDTH-1:0] req,
    input  FpOp                          op [`FP_DIVSQRT_WIDTH],
    input  logic [31:0]                  dataA [`FP_DIVSQRT_WIDTH],
    input  logic [31:0]                  dataB [`FP_DIVSQRT_WIDTH],

    // Recovery
    input  logic                         toRecovery,
    input  ActiveListPtr                 flushHeadPtr,
    input  ActiveListPtr                 flushTailPtr,
    input  logic                         flushAll,

    input  logic                         wbStall,

    output logic [`FP_DIVSQRT_WIDTH-1:0] free,
    output logic [`FP_DIVSQRT_WIDTH-1:0] busy,
    output logic [`FP_DIVSQRT_WIDTH-1:0] reserved,

    output logic                         wbValid,
    output logic [LaneBits-1:0]          wbLane,
    output ActiveListPtr                 wbPtr,
    output logic [31:0]                  wbData
);

    localparam int Width = `FP_DIVSQRT_WIDTH;

    logic [Width-1:0] finished;
    logic [Width-1:0] laneRelease;
    logic [31:0]      result [Width];
    ActiveListPtr     lanePtr [Width];

    fpDivSqrtUnit i_unit (
        .clk          (clk),
        .rstN         (rstN),
        .acquire      (acquire),
        .acquirePtr   (acquirePtr),
        .req          (req),
        .op           (op),
        .dataA        (dataA),
        .dataB        (dataB),
        .toRecovery   (toRecovery),
        .flushAll     (flushAll),
        .flushHeadPtr (flushHeadPtr),
        .flushTailPtr (flushTailPtr),
        .laneRelease  (laneRelease),
        .free         (free),
        .busy         (busy),
        .reserved     (reserved),
        .finished     (finished),
        .result       (result),
        .lanePtr      (lanePtr)
    );

    divSqrtWritebackArbiter #(
        .LaneBits (LaneBits)
    ) i_arbiter (
        .clk         (clk),
        .rstN        (rstN),
        .finished    (finished),
        .result      (result),
        .lanePtr     (lanePtr),
        .wbStall     (wbStall),
        .laneRelease (laneRelease),
        .wbValid     (wbValid),
        .wbLane      (wbLane),
        .wbPtr       (wbPtr),
        .wbData      (wbData)
    );

endmodule

/* design/divSqrtWritebackArbiter.sv */
//////////////////////////////
// Round-robin writeback of finished divide/sqrt lanes
//////////////////////////////

`include "fpDivSqrt_consts.svh"

module divSqrtWritebackArbiter import fpDivSqrtPkg::*; #(
    parameter int LaneBits = (`FP_DIVSQRT_WIDTH > 1) ? $clog2(`FP_DIVSQRT_WIDTH) : 1
) (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [`FP_DIVSQRT_WIDTH-1:0] finished,
    input  logic [31:0]                  result [`FP_DIVSQRT_WIDTH],
    input  ActiveListPtr                 lanePtr [`FP_DIVSQRT_WIDTH],
    input  logic                         wbStall,
    output logic [`FP_DIVSQRT_WIDTH-1:0] laneRelease,
    output logic                         wbValid,
    output logic [LaneBits-1:0]          wbLane,
    output ActiveListPtr                 wbPtr,
    output logic [31:0]                  wbData
);

    localparam int Width = `FP_DIVSQRT_WIDTH;

    logic [LaneBits-1:0] prioLane;
    logic [LaneBits-1:0] scanLane;
    logic [LaneBits-1:0] grantLane;
    logic                grantFound;
    logic                grant;

    // First finished lane at or after the priority pointer
    always_comb begin
        grantFound = 1'b0;
        grantLane = '0;
        scanLane = '0;
        for (int k = 0; k < Width; k++) begin
            scanLane = LaneBits'((int'(prioLane) + k) % Width);
            if (!grantFound && finished[scanLane]) begin
                grantFound = 1'b1;
                grantLane = scanLane;
            end
        end
    end

    assign grant = grantFound && !wbStall;
    assign laneRelease = grant ? (Width'(1) << grantLane) : '0;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbValid <= 1'b0;
            prioLane <= '0;
        end
        else begin
            wbValid <= grant;
            if (grant) begin
                prioLane <= (int'(grantLane) == Width - 1) ? '0 : grantLane + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (grant) begin
            wbLane <= grantLane;
            wbPtr  <= lanePtr[grantLane];
            wbData <= result[grantLane];
        end
    end

endmodule

/* design/fpDivSqrtUnit.sv */
//////////////////////////////
// Divide/sqrt lanes with reservation phases and flush
//////////////////////////////

`include "fpDivSqrt_consts.svh"

module fpDivSqrtUnit import fpDivSqrtPkg::*; (
    input  logic                         clk,
    input  logic                         rstN,
    input  logic [`FP_DIVSQRT_WIDTH-1:0] acquire,
    input  ActiveListPtr                 acquirePtr [`FP_DIVSQRT_WIDTH],
    input  logic [`FP_DIVSQRT_WIDTH-1:0] req,
    input  FpOp                          op [`FP_DIVSQRT_WIDTH],
    input  logic [31:0]                  dataA [`FP_DIVSQRT_WIDTH],
    input  logic [31:0]                  dataB [`FP_DIVSQRT_WIDTH],
    input  logic                         toRecovery,
    input  logic                         flushAll,
    input  ActiveListPtr                 flushHeadPtr,
    input  ActiveListPtr                 flushTailPtr,
    input  logic [`FP_DIVSQRT_WIDTH-1:0] laneRelease,
    output logic [`FP_DIVSQRT_WIDTH-1:0] free,
    output logic [`FP_DIVSQRT_WIDTH-1:0] busy,
    output logic [`FP_DIVSQRT_WIDTH-1:0] reserved,
    output logic [`FP_DIVSQRT_WIDTH-1:0] finished,
    output logic [31:0]                  result [`FP_DIVSQRT_WIDTH],
    output ActiveListPtr                 lanePtr [`FP_DIVSQRT_WIDTH]
);

    localparam int Width = `FP_DIVSQRT_WIDTH;

    DividerPhase  regPhase  [Width];
    DividerPhase  nextPhase [Width];
    ActiveListPtr regPtr    [Width];

    logic [Width-1:0] rangeHit;
    logic [Width-1:0] flush;
    logic [Width-1:0] coreStart;
    logic [Width-1:0] coreDone;

    for (genvar i = 0; i < Width; i++) begin : gLane
        flushRangeDetector i_detector (
            .toRecovery   (toRecovery),
            .flushAll     (flushAll),
            .flushHeadPtr (flushHeadPtr),
            .flushTailPtr (flushTailPtr),
            .ptr          (regPtr[i]),
            .hit          (rangeHit[i])
        );

        // A flushed lane aborts its core in the same cycle
        assign flush[i] = rangeHit[i] && (regPhase[i] != phaseFree);
        assign coreStart[i] = req[i] && (regPhase[i] == phaseReserved);

        fp32DivSqrter i_core (
            .clk    (clk),
            .rstN   (rstN),
            .start  (coreStart[i]),
            .abort  (flush[i]),
            .op     (op[i]),
            .lhs    (dataA[i]),
            .rhs    (dataB[i]),
            .done   (coreDone[i]),
            .result (result[i])
        );

        assign lanePtr[i] = regPtr[i];
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < Width; i++) begin
                regPhase[i] <= phaseFree;
            end
        end
        else begin
            regPhase <= nextPhase;
        end
    end

    // Pointer of the instruction that owns the lane
    always_ff @(posedge clk) begin
        for (int i = 0; i < Width; i++) begin
            if (acquire[i] && regPhase[i] == phaseFree) begin
                regPtr[i] <= acquirePtr[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < Width; i++) begin
            nextPhase[i] = regPhase[i];
            case (regPhase[i])
                phaseFree: begin
                    if (acquire[i]) nextPhase[i] = phaseReserved;
                end
                phaseReserved: begin
                    if (req[i]) nextPhase[i] = phaseProcessing;
                end
                phaseProcessing: begin
                    if (coreDone[i]) nextPhase[i] = phaseWaiting;
                end
                phaseWaiting: begin
                    if (laneRelease[i]) nextPhase[i] = phaseFree;
                end
                default: nextPhase[i] = phaseFree;
            endcase

            // Flush overrides every other transition
            if (flush[i]) begin
                nextPhase[i] = phaseFree;
            end

            // Issue decides on the coming phase, so free looks one edge ahead
            free[i]     = (nextPhase[i] == phaseFree);
            busy[i]     = (regPhase[i] == phaseProcessing);
            reserved[i] = (regPhase[i] == phaseReserved);
            finished[i] = (regPhase[i] == phaseWaiting);
        end
    end

endmodule

/* design/fp32DivSqrter.sv */
//////////////////////////////
// Iterative fp32 divider and square root, truncating
//////////////////////////////

`include "fpDivSqrt_consts.svh"

module fp32DivSqrter import fpDivSqrtPkg::*; (
    input  logic        clk,
    input  logic        rstN,
    input  logic        start,
    input  logic        abort,
    input  FpOp         op,
    input  logic [31:0] lhs,
    input  logic [31:0] rhs,
    output logic        done,
    output logic [31:0] result
);

    localparam int Iters = `DIVSQRT_ITERATIONS;
    localparam int CountBits = $clog2(Iters + 1);
    localparam int RadBits = 2 * Iters;
    localparam int RemBits = Iters + 3;

    // Unpacked operands
    logic        lhsSign;
    logic        rhsSign;
    logic [7:0]  lhsExp;
    logic [7:0]  rhsExp;
    logic [23:0] lhsMant;
    logic [23:0] rhsMant;
    logic        lhsZero;
    logic        rhsZero;

    logic signed [9:0]  divExp;
    logic signed [9:0]  sqrtUnbExp;
    logic signed [9:0]  sqrtExp;
    logic [RadBits-1:0] sqrtRadicand;

    logic        startSpecial;
    logic [31:0] startSpecialValue;

    // Control state
    logic                 busy;
    logic [CountBits-1:0] iterLeft;

    // Operation in flight
    FpOp                curOp;
    logic               resSign;
    logic signed [9:0]  resExp;
    logic [23:0]        divisor;
    logic [RadBits-1:0] radShift;
    logic [RemBits-1:0] rem;
    logic [Iters-1:0]   acc;
    logic               isSpecial;
    logic [31:0]        specialValue;

    // One iteration step
    logic               divGe;
    logic [RemBits-1:0] divRemNext;
    logic [RemBits-1:0] sqrtRemShifted;
    logic [RemBits-1:0] sqrtTrial;
    logic               sqrtGe;
    logic [RemBits-1:0] sqrtRemNext;

    // Final packing
    logic              needNorm;
    logic signed [9:0] finalExp;
    logic [22:0]       finalFrac;

    assign lhsSign = lhs[31];
    assign rhsSign = rhs[31];
    assign lhsExp  = lhs[30:23];
    assign rhsExp  = rhs[30:23];
    assign lhsMant = {1'b1, lhs[22:0]};
    assign rhsMant = {1'b1, rhs[22:0]};
    assign lhsZero = (lhsExp == 8'd0);
    assign rhsZero = (rhsExp == 8'd0);

    assign divExp = $signed({2'b00, lhsExp}) - $signed({2'b00, rhsExp}) + 10'sd127;
    assign sqrtUnbExp = $signed({2'b00, lhsExp}) - 10'sd127;
    // Arithmetic shift floors, which drops the odd bit moved into the mantissa
    assign sqrtExp = (sqrtUnbExp >>> 1) + 10'sd127;

    // Odd exponent doubles the radicand
    assign sqrtRadicand = sqrtUnbExp[0] ? {lhsMant, {(RadBits - 24){1'b0}}}
                                        : {1'b0, lhsMant, {(RadBits - 25){1'b0}}};

    // Special results are fixed at start, zero divisor wins over zero dividend
    always_comb begin
        startSpecial = 1'b0;
        startSpecialValue = '0;
        if (op == opDiv) begin
            if (rhsZero) begin
                startSpecial = 1'b1;
                startSpecialValue = {lhsSign ^ rhsSign, 8'hff, 23'd0};
            end
            else if (lhsZero) begin
                startSpecial = 1'b1;
                startSpecialValue = {lhsSign ^ rhsSign, 31'd0};
            end
        end
        else begin
            if (lhsZero) begin
                startSpecial = 1'b1;
                startSpecialValue = {lhsSign, 31'd0};
            end
            else if (lhsSign) begin
                startSpecial = 1'b1;
                startSpecialValue = 32'h7fc00000;
            end
        end
    end

    // Restoring division step
    assign divGe = rem >= {{(RemBits - 24){1'b0}}, divisor};
    assign divRemNext = (divGe ? rem - {{(RemBits - 24){1'b0}}, divisor} : rem) << 1;

    // Bit-by-bit square root step, two radicand bits per iteration
    assign sqrtRemShifted = {rem[RemBits-3:0], radShift[RadBits-1 -: 2]};
    assign sqrtTrial = {1'b0, acc, 2'b01};
    assign sqrtGe = sqrtRemShifted >= sqrtTrial;
    assign sqrtRemNext = sqrtGe ? sqrtRemShifted - sqrtTrial : sqrtRemShifted;

    // Quotient below one is shifted up by one bit
    assign needNorm = (curOp == opDiv) && !acc[Iters-1];
    assign finalExp = needNorm ? resExp - 10'sd1 : resExp;
    assign finalFrac = needNorm ? acc[Iters-3 -: 23] : acc[Iters-2 -: 23];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            busy <= 1'b0;
            done <= 1'b0;
            iterLeft <= '0;
        end
        else begin
            done <= 1'b0;
            if (abort) begin
                busy <= 1'b0;
            end
            else if (start) begin
                busy <= 1'b1;
                iterLeft <= CountBits'(Iters);
            end
            else if (busy) begin
                if (iterLeft != '0) begin
                    iterLeft <= iterLeft - 1'b1;
                end
                else begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            curOp <= op;
            isSpecial <= startSpecial;
            specialValue <= startSpecialValue;
            divisor <= rhsMant;
            radShift <= sqrtRadicand;
            acc <= '0;
            if (op == opDiv) begin
                rem <= {{(RemBits - 24){1'b0}}, lhsMant};
                resSign <= lhsSign ^ rhsSign;
                resExp <= divExp;
            end
            else begin
                rem <= '0;
                resSign <= 1'b0;
                resExp <= sqrtExp;
            end
        end
        else if (busy && iterLeft != '0) begin
            rem <= (curOp == opDiv) ? divRemNext : sqrtRemNext;
            acc <= {acc[Iters-2:0], (curOp == opDiv) ? divGe : sqrtGe};
            radShift <= radShift << 2;
        end
        else if (busy && !abort) begin
            result <= isSpecial ? specialValue : {resSign, finalExp[7:0], finalFrac};
        end
    end

endmodule

/* design/flushRangeDetector.sv */
//////////////////////////////
// Recovery flush check for one lane pointer
//////////////////////////////

module flushRangeDetector import fpDivSqrtPkg::*; (
    input  logic         toRecovery,
    input  logic         flushAll,
    input  ActiveListPtr flushHeadPtr,
    input  ActiveListPtr flushTailPtr,
    input  ActiveListPtr ptr,
    output logic         hit
);

    logic inRange;

    // Head is inclusive and tail exclusive, equal pointers mean an empty range
    always_comb begin
        inRange = 1'b0;
        if (flushHeadPtr < flushTailPtr) begin
            inRange = (ptr >= flushHeadPtr) && (ptr < flushTailPtr);
        end
        else if (flushHeadPtr > flushTailPtr) begin
            // Range wraps past the top of the active list
            inRange = (ptr >= flushHeadPtr) || (ptr < flushTailPtr);
        end
    end

    assign hit = toRecovery && (flushAll || inRange);

endmodule

/* design/fpDivSqrtPkg.sv */
//////////////////////////////
// Types of the FP divide/sqrt block
//////////////////////////////

`include "fpDivSqrt_consts.svh"

package fpDivSqrtPkg;

    // Reservation state of one lane
    typedef enum logic [1:0] {
        phaseFree       = 2'd0,
        phaseReserved   = 2'd1,
        phaseProcessing = 2'd2,
        phaseWaiting    = 2'd3
    } DividerPhase;

    typedef enum logic {
        opDiv  = 1'b0,
        opSqrt = 1'b1
    } FpOp;

    typedef logic [`ACTIVE_LIST_PTR_BITS-1:0] ActiveListPtr;

endpackage

/* design/fpDivSqrt_consts.svh */
//////////////////////////////
// Shared sizes of the FP divide/sqrt block
//////////////////////////////

`ifndef FP_DIVSQRT_CONSTS_SVH
`define FP_DIVSQRT_CONSTS_SVH

// Number of divide/sqrt lanes
`define FP_DIVSQRT_WIDTH 2

// Width of an active-list pointer
`define ACTIVE_LIST_PTR_BITS 6

// Mantissa iterations per operation, sets the core latency
`define DIVSQRT_ITERATIONS 26

`endif
